// File: logic/i2c_data_pkg.sv
package i2c_data_pkg;

	import i2c_proto_pkg::*;

	// --------------------
	// Payload words
	// --------------------
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// One received word with the address it was sent to
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		word_t             data;
	} rx_entry_t;

endpackage

// File: logic/i2c_line_filter.sv
module i2c_line_filter #(
	parameter int GLITCH_LEN = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic scl_i,
	input  logic sda_i,
	output logic scl_o,
	output logic sda_o,
	output logic scl_rise_o,
	output logic scl_fall_o,
	output logic start_o,
	output logic stop_o
);

	localparam int SCL = 1;
	localparam int SDA = 0;

	logic [1:0]            pin_raw;
	logic [GLITCH_LEN-1:0] hist [2];
	logic [1:0]            level_q; // Clean levels
	logic [1:0]            level_d; // Same, one cycle older

	assign pin_raw = {scl_i, sda_i};

	// Raw sample history
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			hist[i] <= {hist[i][GLITCH_LEN-2:0], pin_raw[i]};
		end
	end

	// Level moves only when the older samples all agree
	always_ff @(posedge clk) begin
		if (rst) begin
			level_q <= '1; // Idle bus is high
			level_d <= '1;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (&hist[i][GLITCH_LEN-1:1])
					level_q[i] <= 1'b1;
				else if (~|hist[i][GLITCH_LEN-1:1])
					level_q[i] <= 1'b0;
			end
			level_d <= level_q;
		end
	end

	// --------------------
	// Edge and condition strobes
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_rise_o <= 1'b0;
			scl_fall_o <= 1'b0;
			start_o    <= 1'b0;
			stop_o     <= 1'b0;
		end else begin
			scl_rise_o <= level_q[SCL] & ~level_d[SCL];
			scl_fall_o <= ~level_q[SCL] & level_d[SCL];
			// SDA moving while SCL holds high
			start_o    <= level_q[SCL] & level_d[SCL] & level_d[SDA] & ~level_q[SDA];
			stop_o     <= level_q[SCL] & level_d[SCL] & ~level_d[SDA] & level_q[SDA];
		end
	end

	assign scl_o = level_q[SCL];
	assign sda_o = level_q[SDA];

endmodule

// File: logic/i2c_proto_pkg.sv
package i2c_proto_pkg;

	// --------------------
	// Addressing
	// --------------------
	localparam int ADDR_W = 7;

	// Addresses accepted on top of the local one
	localparam logic [ADDR_W-1:0] GEN_CALL_ADDR = 7'h00;
	localparam logic [ADDR_W-1:0] SHARED_ADDR_A = 7'h40;
	localparam logic [ADDR_W-1:0] SHARED_ADDR_B = 7'h41;

	// Data bytes per queued word, MSB first
	localparam int BYTES_PER_WORD = 4;

	// --------------------
	// Controller states
	// --------------------
	typedef enum logic [2:0] {
		ST_IDLE     = 3'd0,
		ST_ADDR     = 3'd1, // Address byte coming in
		ST_WRITE    = 3'd2,
		ST_READ     = 3'd3,
		ST_DACK_OUT = 3'd4, // Slave acks a data byte
		ST_AACK_OUT = 3'd5, // Slave acks (or not) the address
		ST_ACK_IN   = 3'd6  // Master acks a read byte
	} ctrl_state_t;

endpackage

// File: logic/i2c_shift_reg.sv
module i2c_shift_reg import i2c_data_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       sda_i,
	input  logic       shift_in_i,
	input  logic       shift_out_i,
	input  logic       load_i,
	input  word_t      load_word_i,
	output word_t      word_o,
	output logic [7:0] byte_o,
	output logic       msb_o
);

	word_t word_q;

	// --------------------
	// Shift buffer
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			word_q <= '0;
		end else if (load_i) begin
			word_q <= load_word_i; // New transmit word wins
		end else if (shift_in_i) begin
			word_q <= {word_q[WORD_W-2:0], sda_i};
		end else if (shift_out_i) begin
			word_q <= {word_q[WORD_W-2:0], 1'b0};
		end
	end

	assign word_o = word_q;
	assign byte_o = word_q[7:0];        // Last byte received
	assign msb_o  = word_q[WORD_W-1];   // Next bit to send

endmodule

// File: logic/i2c_slave_ctrl.sv
module i2c_slave_ctrl import i2c_proto_pkg::*, i2c_data_pkg::*; #(
	parameter int ACK_HOLD = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              scl_i,
	input  logic              sda_i,
	input  logic              scl_rise_i,
	input  logic              scl_fall_i,
	input  logic              start_i,
	input  logic              stop_i,
	input  logic [ADDR_W-1:0] own_addr_i,
	input  logic [7:0]        shift_byte_i,
	input  logic              shift_msb_i,
	input  logic              rx_full_i,
	input  logic              tx_empty_i,
	output logic              shift_in_o,
	output logic              shift_out_o,
	output logic              load_o,
	output logic              rx_push_o,
	output logic [ADDR_W-1:0] rx_addr_o,
	output logic              tx_pop_o,
	output logic              sda_oe_o,
	output logic              wr_stop_o,
	output logic              rd_stop_o,
	output logic              rd_err_o
);

	localparam int HOLD_W     = $clog2(ACK_HOLD + 1);
	localparam int BYTE_CNT_W = $clog2(WORD_W / 8);

	ctrl_state_t           state, state_nxt;
	logic [2:0]            bit_cnt;
	logic [BYTE_CNT_W-1:0] byte_cnt;
	logic [HOLD_W-1:0]     hold_cnt;
	logic                  hold_done;
	logic                  start_seen;
	logic                  rw_flag;     // 1 for a read transfer
	logic                  addr_ack;
	logic                  master_nack;
	logic                  byte_end;
	logic                  word_end;
	logic                  rd_mismatch;
	logic [ADDR_W-1:0]     addr_in;
	logic                  addr_hit;
	logic                  addr_ok;

	assign byte_end = scl_fall_i && (bit_cnt == 3'd7);
	assign word_end = byte_cnt == BYTE_CNT_W'(BYTES_PER_WORD - 1);

	// Address byte is in the low byte of the shift register
	assign addr_in  = shift_byte_i[7:1];
	assign addr_hit = (addr_in == own_addr_i) || (addr_in == GEN_CALL_ADDR) ||
	                  (addr_in == SHARED_ADDR_A) || (addr_in == SHARED_ADDR_B);
	assign addr_ok  = addr_hit && (shift_byte_i[0] ? !tx_empty_i : !rx_full_i);

	// Released bit read back low
	assign rd_mismatch = (state == ST_READ) && scl_rise_i && (sda_i != !sda_oe_o);

	// --------------------
	// State machine
	// --------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:     if (start_seen && scl_fall_i) state_nxt = ST_ADDR;
			ST_ADDR:     if (byte_end) state_nxt = ST_AACK_OUT;
			ST_WRITE:    if (byte_end) state_nxt = ST_DACK_OUT;
			ST_READ: begin
				if (rd_mismatch)
					state_nxt = ST_IDLE;
				else if (byte_end)
					state_nxt = ST_ACK_IN;
			end
			ST_DACK_OUT: if (scl_fall_i) state_nxt = ST_WRITE;
			ST_AACK_OUT: begin
				if (scl_fall_i)
					state_nxt = !addr_ack ? ST_IDLE : (rw_flag ? ST_READ : ST_WRITE);
			end
			ST_ACK_IN:   if (scl_fall_i) state_nxt = master_nack ? ST_IDLE : ST_READ;
			default:     state_nxt = ST_IDLE;
		endcase
		if (start_i || stop_i)
			state_nxt = ST_IDLE; // Any start or stop ends the transfer
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		if (rst)
			start_seen <= 1'b0;
		else if (start_i)
			start_seen <= 1'b1;
		else if (scl_fall_i)
			start_seen <= 1'b0;
	end

	// Bit and byte counters
	always_ff @(posedge clk) begin
		if (rst || state == ST_IDLE) begin
			bit_cnt  <= '0;
			byte_cnt <= '0; // Partial word dropped here
		end else begin
			if ((state == ST_ADDR || state == ST_WRITE || state == ST_READ) && scl_fall_i)
				bit_cnt <= bit_cnt + 3'd1;
			if ((state == ST_WRITE || state == ST_READ) && byte_end)
				byte_cnt <= word_end ? '0 : byte_cnt + 1'b1;
		end
	end

	// Delay after each SCL fall, never ends with SCL high
	always_ff @(posedge clk) begin
		if (rst)
			hold_cnt <= '0;
		else if (scl_fall_i)
			hold_cnt <= HOLD_W'(1);
		else if (hold_cnt == HOLD_W'(ACK_HOLD))
			hold_cnt <= '0;
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt + 1'b1;
	end

	assign hold_done = (hold_cnt == HOLD_W'(ACK_HOLD)) && !scl_i;

	// --------------------
	// Address decision
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_ack <= 1'b0;
			rw_flag  <= 1'b0;
		end else if (state == ST_ADDR && byte_end) begin
			addr_ack <= addr_ok;
			rw_flag  <= shift_byte_i[0];
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_ADDR && byte_end)
			rx_addr_o <= addr_in;
	end

	// Master ack sampled on the ack-in rise
	always_ff @(posedge clk) begin
		if (rst)
			master_nack <= 1'b1;
		else if (state == ST_ACK_IN && scl_rise_i)
			master_nack <= sda_i;
	end

	// --------------------
	// SDA drive
	// --------------------
	always_ff @(posedge clk) begin
		if (rst || state == ST_IDLE) begin
			sda_oe_o <= 1'b0;
		end else if (hold_done) begin
			case (state)
				ST_AACK_OUT: sda_oe_o <= addr_ack;
				ST_DACK_OUT: sda_oe_o <= 1'b1;
				ST_READ:     sda_oe_o <= !shift_msb_i; // Pull low for a 0
				default:     sda_oe_o <= 1'b0;
			endcase
		end
	end

	assign shift_in_o  = scl_rise_i && (state == ST_ADDR || state == ST_WRITE);
	assign shift_out_o = scl_rise_i && (state == ST_READ);
	assign load_o      = tx_pop_o; // Head is taken as it is popped

	// FIFO strobes and status pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_push_o <= 1'b0;
			tx_pop_o  <= 1'b0;
			wr_stop_o <= 1'b0;
			rd_stop_o <= 1'b0;
			rd_err_o  <= 1'b0;
		end else begin
			rx_push_o <= (state == ST_WRITE) && byte_end && word_end;
			tx_pop_o  <= (state == ST_AACK_OUT && scl_rise_i && addr_ack && rw_flag) ||
			             (state == ST_ACK_IN && scl_rise_i && !sda_i && byte_cnt == '0);
			wr_stop_o <= (state == ST_WRITE) && (start_i || stop_i);
			rd_stop_o <= (state == ST_ACK_IN) && scl_fall_i && master_nack;
			rd_err_o  <= rd_mismatch;
		end
	end

endmodule

// File: logic/i2c_slave_top.sv
module i2c_slave_top import i2c_proto_pkg::*, i2c_data_pkg::*; #(
	parameter int GLITCH_LEN = 4,
	parameter int ACK_HOLD   = 8,
	parameter int FIFO_DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              scl_i,
	input  logic              sda_i,
	output logic              sda_oe_o,
	input  logic [ADDR_W-1:0] own_addr_i,
	output rx_entry_t         rx_entry_o,
	output logic              rx_valid_o,
	input  logic              rx_pop_i,
	input  logic              tx_push_i,
	input  word_t             tx_data_i,
	output logic              tx_full_o,
	output logic              wr_stop_o,
	output logic              rd_stop_o,
	output logic              rd_err_o
);

	logic              scl_level, sda_level;
	logic              scl_rise, scl_fall;
	logic              bus_start, bus_stop;
	logic              shift_in_en, shift_out_en, load_en;
	logic [7:0]        shift_byte;
	logic              shift_msb;
	word_t             shift_word;
	logic              rx_push, rx_full, rx_empty;
	logic [ADDR_W-1:0] rx_addr;
	rx_entry_t         rx_push_entry;
	logic              tx_pop, tx_empty;
	word_t             tx_head;

	// --------------------
	// Bus side
	// --------------------
	i2c_line_filter #(.GLITCH_LEN(GLITCH_LEN)) i_filter (
		.clk(clk), .rst(rst),
		.scl_i(scl_i), .sda_i(sda_i),
		.scl_o(scl_level), .sda_o(sda_level),
		.scl_rise_o(scl_rise), .scl_fall_o(scl_fall),
		.start_o(bus_start), .stop_o(bus_stop)
	);

	i2c_slave_ctrl #(.ACK_HOLD(ACK_HOLD)) i_ctrl (
		.clk(clk), .rst(rst),
		.scl_i(scl_level), .sda_i(sda_level),
		.scl_rise_i(scl_rise), .scl_fall_i(scl_fall),
		.start_i(bus_start), .stop_i(bus_stop),
		.own_addr_i(own_addr_i),
		.shift_byte_i(shift_byte), .shift_msb_i(shift_msb),
		.rx_full_i(rx_full), .tx_empty_i(tx_empty),
		.shift_in_o(shift_in_en), .shift_out_o(shift_out_en), .load_o(load_en),
		.rx_push_o(rx_push), .rx_addr_o(rx_addr), .tx_pop_o(tx_pop),
		.sda_oe_o(sda_oe_o),
		.wr_stop_o(wr_stop_o), .rd_stop_o(rd_stop_o), .rd_err_o(rd_err_o)
	);

	i2c_shift_reg i_shift (
		.clk(clk), .rst(rst), .sda_i(sda_level),
		.shift_in_i(shift_in_en), .shift_out_i(shift_out_en),
		.load_i(load_en), .load_word_i(tx_head),
		.word_o(shift_word), .byte_o(shift_byte), .msb_o(shift_msb)
	);

	// --------------------
	// Host side queues
	// --------------------
	assign rx_push_entry = '{addr: rx_addr, data: shift_word};
	assign rx_valid_o    = !rx_empty;

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(rx_entry_t)) rx_fifo (
		.clk(clk), .rst(rst),
		.push_i(rx_push), .push_data_i(rx_push_entry), .pop_i(rx_pop_i),
		.full_o(rx_full), .empty_o(rx_empty), .head_o(rx_entry_o)
	);

	word_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(word_t)) tx_fifo (
		.clk(clk), .rst(rst),
		.push_i(tx_push_i), .push_data_i(tx_data_i), .pop_i(tx_pop),
		.full_o(tx_full_o), .empty_o(tx_empty), .head_o(tx_head)
	);

endmodule

// File: logic/word_fifo.sv
module word_fifo #(
	parameter int  FIFO_DEPTH = 4,
	parameter type payload_t  = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push_i,
	input  payload_t push_data_i,
	input  logic     pop_i,
	output logic     full_o,
	output logic     empty_o,
	output payload_t head_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	payload_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full_o  = count == CNT_W'(FIFO_DEPTH);
	assign empty_o = count == '0;

	// Strobes that would over- or underflow are ignored
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	// --------------------
	// Pointers and occupancy
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	assign head_o = mem[rd_ptr]; // Valid while not empty

endmodule

// File: project.f
logic/i2c_proto_pkg.sv
logic/i2c_data_pkg.sv
logic/i2c_line_filter.sv
logic/i2c_slave_ctrl.sv
logic/i2c_shift_reg.sv
logic/word_fifo.sv
logic/i2c_slave_top.sv
+incdir+verif
verif/tb_i2c_slave.sv

// File: verif/i2c_master_tasks.svh
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// Bus master tasks for the testbench module
// All bus changes happen on falling clock edges
// SCL is low on entry and exit of every task except after a stop

task automatic bus_wait(input int n);
	repeat (n) @(negedge clk);
endtask

// --------------------
// Start and stop
// --------------------
task automatic send_start;
	sda_m = 1'b1;
	bus_wait(QTR);
	scl_m = 1'b1;
	bus_wait(QTR);
	sda_m = 1'b0; // SDA falls with SCL high
	bus_wait(2 * QTR);
	scl_m = 1'b0;
	bus_wait(QTR);
endtask

task automatic send_stop;
	sda_m = 1'b0;
	bus_wait(QTR);
	scl_m = 1'b1;
	bus_wait(2 * QTR);
	sda_m = 1'b1; // SDA rises with SCL high
	bus_wait(2 * QTR);
endtask

// One bit slot that returns the bus level in mid high phase
task automatic clock_bit(input logic drive, output logic seen);
	sda_m = drive;
	bus_wait(QTR);
	scl_m = 1'b1;
	bus_wait(QTR);
	seen = sda_bus;
	bus_wait(QTR);
	scl_m = 1'b0;
	bus_wait(QTR);
endtask

// --------------------
// Bytes
// --------------------
task automatic write_byte(input logic [7:0] data, output logic acked);
	logic seen;
	for (int i = 7; i >= 0; i--)
		clock_bit(data[i], seen);
	clock_bit(1'b1, seen); // Released for the slave ack
	acked = !seen;
endtask

// Master pulls bit low_bit low, or no bit for -1
task automatic read_byte(input logic ack, input int low_bit, output logic [7:0] data);
	logic seen;
	for (int i = 7; i >= 0; i--) begin
		clock_bit(i != low_bit, seen);
		data[i] = seen;
	end
	clock_bit(!ack, seen);
endtask

`endif

// File: verif/tb_i2c_slave.sv
module tb_i2c_slave import i2c_proto_pkg::*, i2c_data_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int QTR        = 20; // Clocks per quarter bit time
	localparam int FIFO_DEPTH = 4;
	localparam logic [ADDR_W-1:0] OWN_ADDR = 7'h2a;
	// Bus bytes and transfer frames over all tests
	localparam int PLANNED_BYTES = 56;
	localparam int PLANNED_XFERS = 10;
	// Nine slots of four quarters per byte and ten quarters of start and stop per transfer
	localparam int WATCHDOG_TIME =
		2 * CLK_PERIOD * QTR * (PLANNED_BYTES * 36 + PLANNED_XFERS * 10);

	logic clk, rst, scl_m, sda_m, sda_bus, sda_oe;
	logic [ADDR_W-1:0] own_addr;
	rx_entry_t rx_entry;
	logic rx_valid, rx_pop, tx_push, tx_full;
	word_t tx_data;
	logic wr_stop, rd_stop, rd_err;
	int checks, errors, wr_stops, rd_stops, rd_errs, exp_wr, exp_rd, exp_err;
	logic err_window;
	rx_entry_t exp_q[$];
	word_t tx_q[$];

	assign sda_bus = sda_m & ~sda_oe; // Open-drain wired-AND

	always #(CLK_PERIOD / 2) clk = ~clk;

	i2c_slave_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (
		.clk(clk), .rst(rst), .scl_i(scl_m), .sda_i(sda_bus), .sda_oe_o(sda_oe),
		.own_addr_i(own_addr), .rx_entry_o(rx_entry), .rx_valid_o(rx_valid),
		.rx_pop_i(rx_pop), .tx_push_i(tx_push), .tx_data_i(tx_data), .tx_full_o(tx_full),
		.wr_stop_o(wr_stop), .rd_stop_o(rd_stop), .rd_err_o(rd_err)
	);

	`include "i2c_master_tasks.svh"

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
	                           input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_event(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("%s, at time %0t", what, $time);
		end
	endtask

	// --------------------
	// Pulse monitor
	// --------------------
	always @(negedge clk) begin
		if (!rst) begin
			wr_stops += wr_stop;
			rd_stops += rd_stop;
			rd_errs  += rd_err;
			if (rd_err)
				err_window = 1'b1;
			else if (i_dut.bus_start)
				err_window = 1'b0;
			if (err_window)
				assert (!sda_oe) else begin
					errors++;
					$display("Slave drove SDA after a read error, at time %0t", $time);
				end
		end
	end

	task automatic check_pulses(input string what);
		check_value(wr_stops, exp_wr, {what, ": write stop pulses"});
		check_value(rd_stops, exp_rd, {what, ": read stop pulses"});
		check_value(rd_errs, exp_err, {what, ": read error pulses"});
	endtask

	// Words are built MSB first from groups of four bytes
	// A trailing partial word is dropped
	task automatic write_words(input logic [ADDR_W-1:0] addr, input int nbytes,
	                           input logic exp_ack);
		logic acked;
		logic [7:0] data;
		word_t word;
		send_start();
		write_byte({addr, 1'b0}, acked);
		check_event(acked == exp_ack,
		            $sformatf("Wrong address ack for a write to %h", addr));
		if (acked && exp_ack) begin
			for (int i = 0; i < nbytes; i++) begin
				data = 8'($urandom);
				write_byte(data, acked);
				check_event(acked, "Slave did not acknowledge a data byte");
				word = {word[WORD_W-9:0], data};
				if (i % BYTES_PER_WORD == BYTES_PER_WORD - 1)
					exp_q.push_back('{addr: addr, data: word});
			end
			exp_wr++;
		end
		send_stop();
	endtask

	task automatic drain_rx;
		while (rx_valid) begin
			check_event(exp_q.size() != 0, "Receive FIFO holds an unexpected entry");
			if (exp_q.size() != 0)
				check_value(rx_entry, exp_q.pop_front(), "receive entry");
			rx_pop = 1'b1;
			@(negedge clk);
			rx_pop = 1'b0;
			@(negedge clk);
		end
		check_event(exp_q.size() == 0, "An expected receive entry never appeared");
		exp_q.delete();
	endtask

	task automatic push_tx(input word_t w);
		tx_data = w;
		tx_push = 1'b1;
		@(negedge clk);
		tx_push = 1'b0;
		tx_q.push_back(w);
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	initial begin
		logic acked;
		logic [7:0] data;
		word_t word;
		clk = 1'b0;
		rst = 1'b1;
		scl_m = 1'b1;
		sda_m = 1'b1;
		own_addr = OWN_ADDR;
		rx_pop = 1'b0;
		tx_push = 1'b0;
		tx_data = '0;
		err_window = 1'b0;
		void'($urandom(32'hefd23d3e));
		repeat (2) @(negedge clk);
		rst = 1'b0;
		bus_wait(8);
		check_event(!sda_oe && !wr_stop && !rd_stop && !rd_err, "Outputs active after reset");
		check_event(!rx_valid && i_dut.tx_empty, "FIFOs not empty after reset");
		check_value(i_dut.i_ctrl.state, ST_IDLE, "controller state after reset");

		write_words(OWN_ADDR, 9, 1'b1); // Ninth byte is dropped
		drain_rx();
		check_pulses("nine byte write");

		write_words(SHARED_ADDR_A, 4, 1'b1);
		write_words(SHARED_ADDR_B, 4, 1'b1);
		write_words(GEN_CALL_ADDR, 4, 1'b1);
		write_words(7'h13, 4, 1'b0);
		drain_rx();
		check_pulses("address filter");

		// --------------------
		// Reads
		// --------------------
		push_tx($urandom);
		push_tx($urandom);
		send_start();
		write_byte({OWN_ADDR, 1'b1}, acked);
		check_event(acked, "Slave did not acknowledge the read address");
		for (int i = 0; i < 2 * BYTES_PER_WORD; i++) begin
			if (i % BYTES_PER_WORD == 0)
				word = tx_q.pop_front();
			read_byte(i != 2 * BYTES_PER_WORD - 1, -1, data);
			check_value(data, word[WORD_W-1 -: 8], "read byte");
			word = word << 8;
		end
		send_stop();
		exp_rd++;
		check_event(i_dut.tx_empty, "Transmit FIFO not empty after the read");
		check_pulses("two word read");

		send_start();
		write_byte({OWN_ADDR, 1'b1}, acked);
		check_event(!acked, "Read with an empty transmit FIFO was acknowledged");
		send_stop();
		write_words(OWN_ADDR, FIFO_DEPTH * BYTES_PER_WORD, 1'b1);
		write_words(OWN_ADDR, BYTES_PER_WORD, 1'b0); // Receive FIFO full
		drain_rx();
		check_pulses("back-pressure");

		push_tx($urandom | 32'h8000_0000); // First bit released by the slave
		for (int i = 1; i < FIFO_DEPTH; i++)
			push_tx($urandom);
		check_value(tx_full, 1'b1, "transmit FIFO full flag when filled");
		send_start();
		write_byte({OWN_ADDR, 1'b1}, acked);
		check_event(acked, "Slave did not acknowledge the read address");
		read_byte(1'b0, 7, data);
		check_value(data, 8'h7f, "byte after the bus error");
		send_stop();
		check_value(tx_full, 1'b0, "transmit FIFO full flag after one pop");
		exp_err++;
		tx_q.delete();
		check_pulses("read error");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
